// File: files.f
+incdir+include
rtl/ctl_pkg.sv
rtl/spi_reg_if.sv
rtl/spi_frame_rx.sv
rtl/register_set.sv
rtl/sample_acq_pc.sv
rtl/output_mux.sv
rtl/dmm_ctl_top.sv
tests/tb_dmm_ctl.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_dmm_ctl
RTL_TOP   ?= dmm_ctl_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_dmm_ctl.sv
// meter control core testbench
`timescale 1ns/1ps
`include "ctl_consts.svh"

module tb_dmm_ctl;

  localparam int RUN_LIMIT = 100;   // longest legal run is 40

  logic        clk;
  logic        reset_i;
  logic        sck_i, sdi_i, ss_i, spi_cs2_i;
  logic [3:0]  hw_flags_i;
  logic        sdo_o;
  logic        glb_spi_mosi_o, glb_spi_clk_o, glb_4094_oe_ctl_o;
  logic        glb_4094_strobe_ctl_o, spi_dac_ss_o;
  logic [3:0]  leds_o, azmux_o, adc_refmux_o;
  logic [7:0]  monitor_o;
  logic        spi_interrupt_ctl_o, meas_complete_o, adc_cmpr_latch_o;
  logic [1:0]  sig_pc_sw_o;
  logic [24:0] pins_w;                    // pin vector, leds at bit 0

  logic [31:0] lfsr = 32'h2c3992a3;
  logic [31:0] model_regs [0:127];        // register model, holes stay zero
  logic [3:0]  flags_val;
  logic [24:0] pattern_ref;               // pattern counter model
  int          test_idx, tests_failed, test_errors, total_errors;

  dmm_ctl_top i_dmm_ctl_top (
    .clk(clk), .reset_i(reset_i), .sck_i(sck_i), .sdi_i(sdi_i), .ss_i(ss_i),
    .spi_cs2_i(spi_cs2_i), .hw_flags_i(hw_flags_i), .sdo_o(sdo_o),
    .glb_spi_mosi_o(glb_spi_mosi_o), .glb_spi_clk_o(glb_spi_clk_o),
    .glb_4094_oe_ctl_o(glb_4094_oe_ctl_o), .glb_4094_strobe_ctl_o(glb_4094_strobe_ctl_o),
    .spi_dac_ss_o(spi_dac_ss_o), .leds_o(leds_o), .monitor_o(monitor_o),
    .spi_interrupt_ctl_o(spi_interrupt_ctl_o), .meas_complete_o(meas_complete_o),
    .sig_pc_sw_o(sig_pc_sw_o), .azmux_o(azmux_o), .adc_cmpr_latch_o(adc_cmpr_latch_o),
    .adc_refmux_o(adc_refmux_o)
  );

  assign pins_w = {adc_refmux_o, adc_cmpr_latch_o, azmux_o, sig_pc_sw_o,
                   meas_complete_o, spi_interrupt_ctl_o, monitor_o, leds_o};

  always #20 clk = ~clk;   // 40 ns period

  // free running from reset, one step per clk
  always @(posedge clk) begin
    if (reset_i) begin
      pattern_ref <= '0;
    end else begin
      pattern_ref <= pattern_ref + 25'd1;
    end
  end

  ////////////////////////////////////////
  // helpers

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    test_idx++;
    if (test_errors == 0) begin
      $display("test %0d %s: pass", test_idx, name);
    end else begin
      $display("test %0d %s: %0d checks wrong", test_idx, name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  ////////////////////////////////////////
  // register model

  // writable regs keep only their implemented bits
  task automatic model_write(input logic [6:0] addr, input logic [31:0] data);
    case (addr)
      `CTL_ADDR_MODE:      model_regs[addr] = data & 32'h7;
      `CTL_ADDR_PRECHARGE: model_regs[addr] = data & 32'hff_ffff;
      `CTL_ADDR_SPI_MUX, `CTL_ADDR_4094, `CTL_ADDR_DIRECT, `CTL_ADDR_APERTURE:
        model_regs[addr] = data;
      default: ;
    endcase
  endtask

  function automatic logic [31:0] expected_read(input logic [6:0] addr);
    if (addr == `CTL_ADDR_STATUS) return {20'b0, flags_val, `CTL_MAGIC};
    return model_regs[addr];
  endfunction

  function automatic logic [24:0] expected_pins(input logic [2:0] mode,
                                                input logic [31:0] direct);
    case (mode)
      `CTL_MODE_DIRECT: return direct[`CTL_OUT_BITS-1:0];
      `CTL_MODE_HI:     return '1;
      default:          return '0;   // lo and unused codes
    endcase
  endfunction

  function automatic logic [6:0] pick_addr(input int k);
    case (k)
      0:       return `CTL_ADDR_SPI_MUX;
      1:       return `CTL_ADDR_4094;
      2:       return `CTL_ADDR_MODE;
      3:       return `CTL_ADDR_DIRECT;
      4:       return `CTL_ADDR_APERTURE;
      default: return `CTL_ADDR_PRECHARGE;
    endcase
  endfunction

  ////////////////////////////////////////
  // spi master, mode 0, 4 clk per phase

  task automatic spi_frame(input logic wr, input logic [6:0] addr, input logic [31:0] data,
                           input int nbits, output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr, data};
    rdata = '0;
    @(posedge clk);
    ss_i <= 1'b0;
    wait_cycles(4);
    for (int i = 0; i < nbits; i++) begin
      sck_i <= 1'b0;               // sdo moves on this fall
      sdi_i <= frame[39-i];
      wait_cycles(3);
      @(negedge clk);
      if (i >= 8) rdata = {rdata[30:0], sdo_o};
      @(posedge clk);
      sck_i <= 1'b1;               // dut samples sdi
      wait_cycles(4);
    end
    sck_i <= 1'b0;
    wait_cycles(4);
    ss_i <= 1'b1;
    wait_cycles(8);                // commit plus two cycles to the pins
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    spi_frame(1'b1, addr, data, `CTL_FRAME_BITS, unused_rd);
    model_write(addr, data);
  endtask

  task automatic spi_read(input logic [6:0] addr, output logic [31:0] data);
    spi_frame(1'b0, addr, rand_bits(32), `CTL_FRAME_BITS, data);
  endtask

  ////////////////////////////////////////
  // precharge run measurement

  task automatic wait_pc_level(input logic level);
    int n;
    n = 0;
    while (sig_pc_sw_o[0] !== level && n < RUN_LIMIT) begin
      n++;
      @(negedge clk);
    end
    if (sig_pc_sw_o[0] !== level) timeout_abort("sig_pc_sw_o[0] never changed");
  endtask

  task automatic measure_run(input logic level, input logic exp_led, output int len);
    len = 0;
    while (sig_pc_sw_o[0] === level && len < RUN_LIMIT) begin
      check_value("sig_pc_sw_o[1]", 32'(sig_pc_sw_o[1]), 32'd0);
      check_value("leds_o[0]", 32'(leds_o[0]), 32'(exp_led));
      len++;
      @(negedge clk);
    end
    if (len == RUN_LIMIT) timeout_abort("precharge phase never ended");
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] rd, d;
    logic [6:0]  a;
    logic [24:0] exp_pat;
    logic        led_ref;
    int          p, ap, hi, lo, nb;
    clk = 1'b0;
    reset_i <= 1'b1;
    sck_i <= 1'b0;
    sdi_i <= 1'b0;
    ss_i <= 1'b1;                  // deselected
    spi_cs2_i <= 1'b1;
    hw_flags_i <= '0;
    flags_val = '0;
    for (int i = 0; i < 128; i++) model_regs[i] = '0;
    wait_cycles(2);
    reset_i <= 1'b0;
    @(negedge clk);

    // 1: reset state
    check_value("pins", 32'(pins_w), 32'd0);
    check_value("glb_spi_clk_o", 32'(glb_spi_clk_o), 32'd1);
    check_value("glb_spi_mosi_o", 32'(glb_spi_mosi_o), 32'd1);
    check_value("spi_dac_ss_o", 32'(spi_dac_ss_o), 32'd1);
    check_value("strobe", 32'(glb_4094_strobe_ctl_o), 32'd0);
    check_value("oe", 32'(glb_4094_oe_ctl_o), 32'd0);
    check_value("sdo_o", 32'(sdo_o), 32'd0);
    finish_test("reset state");

    // 2: register write and read back
    for (int k = 0; k < 12; k++) begin
      a = pick_addr(int'(rand_bits(3) % 32'd6));
      spi_write(a, rand_bits(32));
      spi_read(a, rd);
      check_value("read back", rd, expected_read(a));
    end
    flags_val = 4'(rand_bits(4));
    @(posedge clk);
    hw_flags_i <= flags_val;
    for (int k = 0; k < 7; k++) begin
      spi_read(7'(k), rd);
      check_value("register", rd, expected_read(7'(k)));
    end
    spi_read(7'h40 | 7'(rand_bits(6)), rd);             // hole in the map
    check_value("unmapped", rd, 32'd0);
    for (int k = 0; k < 4; k++) begin
      a  = pick_addr(int'(rand_bits(3) % 32'd6));
      nb = int'(rand_bits(6) % 32'd39) + 1;              // short frame
      spi_frame(1'b1, a, rand_bits(32), nb, rd);
      spi_read(a, rd);
      check_value("after aborted frame", rd, expected_read(a));
    end
    finish_test("register access");

    // 3: direct and constant modes
    spi_write(`CTL_ADDR_DIRECT, rand_bits(32));
    spi_write(`CTL_ADDR_MODE, {29'(rand_bits(29)), `CTL_MODE_DIRECT});
    @(negedge clk);
    check_value("direct pins", 32'(pins_w),
                32'(expected_pins(`CTL_MODE_DIRECT, model_regs[`CTL_ADDR_DIRECT])));
    for (int c = 1; c < 8; c++) begin
      if (c != 3 && c != 4) begin
        spi_write(`CTL_ADDR_MODE, {29'(rand_bits(29)), 3'(c)});
        @(negedge clk);
        check_value("mode pins", 32'(pins_w), 32'(expected_pins(3'(c), 32'd0)));
      end
    end
    finish_test("direct and constant modes");

    // 4: pattern counter, pins one register behind the counter
    spi_write(`CTL_ADDR_MODE, 32'(`CTL_MODE_PATTERN));
    for (int k = 0; k < 20; k++) begin
      @(negedge clk);
      exp_pat = pattern_ref - 25'd1;
      check_value("pattern", 32'(pins_w), 32'(exp_pat));
    end
    finish_test("pattern mode");

    // 5: precharge and sample run lengths
    for (int r = 0; r < 2; r++) begin
      p  = int'(rand_bits(8) % 32'd40) + 1;
      ap = int'(rand_bits(8) % 32'd40) + 1;
      spi_write(`CTL_ADDR_MODE, 32'(`CTL_MODE_DIRECT));
      spi_write(`CTL_ADDR_PRECHARGE, 32'(p));
      spi_write(`CTL_ADDR_APERTURE, 32'(ap));
      spi_write(`CTL_ADDR_MODE, 32'(`CTL_MODE_PC));
      @(negedge clk);
      wait_pc_level(1'b0);
      wait_pc_level(1'b1);         // start of a full period
      led_ref = leds_o[0];
      for (int k = 0; k < 3; k++) begin
        measure_run(1'b1, led_ref, hi);
        check_value("precharge run", 32'(hi), 32'(p));
        measure_run(1'b0, led_ref, lo);
        check_value("sample run", 32'(lo), 32'(ap));
        led_ref = ~led_ref;        // toggles with each new period
      end
    end
    finish_test("precharge sequencer");

    // 6: spi line routing
    for (int m = 0; m < 3; m++) begin
      spi_write(`CTL_ADDR_SPI_MUX, 32'(m));
      for (int k = 0; k < 16; k++) begin
        @(posedge clk);
        d = rand_bits(3);
        sck_i <= d[0];
        sdi_i <= d[1];
        spi_cs2_i <= d[2];
        @(negedge clk);
        check_value("glb clk", 32'(glb_spi_clk_o), (m == 0) ? 32'd1 : 32'(d[0]));
        check_value("glb mosi", 32'(glb_spi_mosi_o), (m == 0) ? 32'd1 : 32'(d[1]));
        check_value("strobe", 32'(glb_4094_strobe_ctl_o), (m == 1) ? 32'(!d[2]) : 32'd0);
        check_value("dac select", 32'(spi_dac_ss_o), (m == 2) ? 32'(d[2]) : 32'd1);
        check_value("oe", 32'(glb_4094_oe_ctl_o), 32'(model_regs[`CTL_ADDR_4094][0]));
        check_value("strobe with dac select",
                    32'(glb_4094_strobe_ctl_o & ~spi_dac_ss_o), 32'd0);
      end
      @(posedge clk);
      sck_i <= 1'b0;
      sdi_i <= 1'b0;
      spi_cs2_i <= 1'b1;
    end
    finish_test("spi routing");

    $display("%0d tests run, %0d failed, %0d checks wrong",
             test_idx, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: rtl/dmm_ctl_top.sv
// meter control core top
`timescale 1ns/1ps

module dmm_ctl_top (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        sck_i,
  input  logic        sdi_i,
  input  logic        ss_i,
  input  logic        spi_cs2_i,
  input  logic [3:0]  hw_flags_i,
  output logic        sdo_o,
  output logic        glb_spi_mosi_o,
  output logic        glb_spi_clk_o,
  output logic        glb_4094_oe_ctl_o,
  output logic        glb_4094_strobe_ctl_o,
  output logic        spi_dac_ss_o,
  output logic [3:0]  leds_o,
  output logic [7:0]  monitor_o,
  output logic        spi_interrupt_ctl_o,
  output logic        meas_complete_o,
  output logic [1:0]  sig_pc_sw_o,
  output logic [3:0]  azmux_o,
  output logic        adc_cmpr_latch_o,
  output logic [3:0]  adc_refmux_o
);

  import ctl_pkg::*;

  cfg_t        cfg;
  pins_t       pins;
  logic        sw_pc;
  logic        led0;
  logic [7:0]  pc_monitor;

  spi_reg_if i_bus ();

  ////////////////////////////////////////
  // pipeline stages

  spi_frame_rx i_spi_frame_rx (
    .clk      (clk),
    .reset_i  (reset_i),
    .sck_i    (sck_i),
    .ss_i     (ss_i),
    .sdi_i    (sdi_i),
    .sdo_o    (sdo_o),
    .bus      (i_bus.rx)
  );

  register_set i_register_set (
    .clk                    (clk),
    .reset_i                (reset_i),
    .bus                    (i_bus.regs),
    .hw_flags_i             (hw_flags_i),
    .sck_i                  (sck_i),         // routed live, not synced
    .sdi_i                  (sdi_i),
    .spi_cs2_i              (spi_cs2_i),
    .glb_spi_mosi_o         (glb_spi_mosi_o),
    .glb_spi_clk_o          (glb_spi_clk_o),
    .glb_4094_oe_ctl_o      (glb_4094_oe_ctl_o),
    .glb_4094_strobe_ctl_o  (glb_4094_strobe_ctl_o),
    .spi_dac_ss_o           (spi_dac_ss_o),
    .cfg_o                  (cfg)
  );

  sample_acq_pc i_sample_acq_pc (
    .clk        (clk),
    .reset_i    (reset_i),
    .cfg_i      (cfg),
    .sw_pc_o    (sw_pc),
    .led0_o     (led0),
    .monitor_o  (pc_monitor)
  );

  output_mux i_output_mux (
    .clk           (clk),
    .reset_i       (reset_i),
    .cfg_i         (cfg),
    .sw_pc_i       (sw_pc),
    .led0_i        (led0),
    .pc_monitor_i  (pc_monitor),
    .pins_o        (pins)
  );

  // pin vector onto board pins
  assign leds_o              = pins.leds;
  assign monitor_o           = pins.monitor;
  assign spi_interrupt_ctl_o = pins.spi_interrupt;
  assign meas_complete_o     = pins.meas_complete;
  assign sig_pc_sw_o         = pins.sig_pc_sw;
  assign azmux_o             = pins.azmux;
  assign adc_cmpr_latch_o    = pins.adc_cmpr_latch;
  assign adc_refmux_o        = pins.adc_refmux;

endmodule

// File: rtl/output_mux.sv
// test pattern and mode select
`timescale 1ns/1ps
`include "ctl_consts.svh"

module output_mux (
  input  logic            clk,
  input  logic            reset_i,
  input  ctl_pkg::cfg_t   cfg_i,
  input  logic            sw_pc_i,
  input  logic            led0_i,
  input  logic [7:0]      pc_monitor_i,
  output ctl_pkg::pins_t  pins_o
);

  import ctl_pkg::*;

  logic [31:0] pattern_q;   // free running
  pins_t       pc_pins;
  pins_t       pins_q;

  ////////////////////////////////////////
  // test pattern

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pattern_q <= '0;
    end else begin
      pattern_q <= pattern_q + 32'd1;
    end
  end

  // precharge mode, pc switch 1 only, rest held low
  always_comb begin
    pc_pins           = '0;
    pc_pins.sig_pc_sw = {1'b0, sw_pc_i};
    pc_pins.monitor   = pc_monitor_i;
    pc_pins.leds[0]   = led0_i;
  end

  ////////////////////////////////////////
  // registered mode select

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pins_q <= '0;             // all pins low
    end else begin
      case (cfg_i.mode)
        MODE_DIRECT:  pins_q <= pins_t'(cfg_i.direct[`CTL_OUT_BITS-1:0]);
        MODE_LO:      pins_q <= '0;
        MODE_HI:      pins_q <= '1;
        MODE_PATTERN: pins_q <= pins_t'(pattern_q[`CTL_OUT_BITS-1:0]);
        MODE_PC:      pins_q <= pc_pins;
        default:      pins_q <= '0;    // codes 5..7
      endcase
    end
  end

  assign pins_o = pins_q;

endmodule

// File: rtl/sample_acq_pc.sv
// precharge sample sequencer
`timescale 1ns/1ps

module sample_acq_pc (
  input  logic           clk,
  input  logic           reset_i,
  input  ctl_pkg::cfg_t  cfg_i,
  output logic           sw_pc_o,
  output logic           led0_o,
  output logic [7:0]     monitor_o
);

  import ctl_pkg::*;

  logic        in_pc;
  logic        active_q;     // in_pc one cycle ago, finds mode entry
  logic        phase_q;      // 1 precharge, 0 sample
  logic [31:0] cnt_q;        // cycles left in phase
  logic        led0_q;
  logic [31:0] pc_len;
  logic [31:0] ap_len;

  assign in_pc  = (cfg_i.mode == MODE_PC);
  assign pc_len = (cfg_i.precharge == 24'd0) ? 32'd1 : {8'b0, cfg_i.precharge};   // min 1
  assign ap_len = (cfg_i.aperture == 32'd0) ? 32'd1 : cfg_i.aperture;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      active_q <= 1'b0;
      phase_q  <= 1'b0;
      cnt_q    <= '0;
      led0_q   <= 1'b0;
    end else begin
      active_q <= in_pc;
      if (!in_pc) begin
        phase_q <= 1'b0;                 // switch open outside pc mode
        cnt_q   <= '0;
      end else if (!active_q || (!phase_q && cnt_q == 32'd1)) begin
        phase_q <= 1'b1;                 // new period, precharge first
        cnt_q   <= pc_len;
        led0_q  <= ~led0_q;
      end else if (cnt_q == 32'd1) begin
        phase_q <= 1'b0;                 // into sample phase
        cnt_q   <= ap_len;
      end else begin
        cnt_q <= cnt_q - 32'd1;
      end
    end
  end

  assign sw_pc_o   = phase_q;
  assign led0_o    = led0_q;
  assign monitor_o = {cnt_q[6:0], phase_q};

  // within a phase the count only steps down and never passes zero
  assert property (@(posedge clk) disable iff (reset_i)
    ($past(active_q && in_pc) && $stable(phase_q)) |-> (cnt_q != '0 && cnt_q == $past(cnt_q) - 32'd1));

endmodule

// File: rtl/register_set.sv
// register file and spi routing
`timescale 1ns/1ps
`include "ctl_consts.svh"

module register_set (
  input  logic           clk,
  input  logic           reset_i,
  spi_reg_if.regs        bus,
  input  logic [3:0]     hw_flags_i,
  input  logic           sck_i,
  input  logic           sdi_i,
  input  logic           spi_cs2_i,
  output logic           glb_spi_mosi_o,
  output logic           glb_spi_clk_o,
  output logic           glb_4094_oe_ctl_o,
  output logic           glb_4094_strobe_ctl_o,
  output logic           spi_dac_ss_o,
  output ctl_pkg::cfg_t  cfg_o
);

  import ctl_pkg::*;

  logic [31:0] spi_mux_q;     // 0 park, 1 4094, 2 dac
  logic [31:0] reg_4094_q;    // bit 0 is oe
  mode_e       mode_q;
  logic [31:0] direct_q;
  logic [31:0] aperture_q;
  logic [23:0] precharge_q;
  logic [31:0] status;

  ////////////////////////////////////////
  // write side

  always_ff @(posedge clk) begin
    if (reset_i) begin
      spi_mux_q   <= '0;
      reg_4094_q  <= '0;        // outputs of 4094 off at power up
      mode_q      <= MODE_DIRECT;
      direct_q    <= '0;
      aperture_q  <= '0;
      precharge_q <= '0;
    end else if (bus.wr_stb) begin
      case (bus.addr)
        `CTL_ADDR_SPI_MUX:   spi_mux_q   <= bus.wdata;
        `CTL_ADDR_4094:      reg_4094_q  <= bus.wdata;
        `CTL_ADDR_MODE:      mode_q      <= mode_e'(bus.wdata[2:0]);
        `CTL_ADDR_DIRECT:    direct_q    <= bus.wdata;
        `CTL_ADDR_APERTURE:  aperture_q  <= bus.wdata;
        `CTL_ADDR_PRECHARGE: precharge_q <= bus.wdata[23:0];
        default: ;          // status and holes ignore writes
      endcase
    end
  end

  ////////////////////////////////////////
  // read side

  assign status = {20'b0, hw_flags_i, `CTL_MAGIC};

  always_comb begin
    case (bus.addr)
      `CTL_ADDR_SPI_MUX:   bus.rdata = spi_mux_q;
      `CTL_ADDR_4094:      bus.rdata = reg_4094_q;
      `CTL_ADDR_MODE:      bus.rdata = {29'b0, mode_q};
      `CTL_ADDR_DIRECT:    bus.rdata = direct_q;
      `CTL_ADDR_STATUS:    bus.rdata = status;
      `CTL_ADDR_APERTURE:  bus.rdata = aperture_q;
      `CTL_ADDR_PRECHARGE: bus.rdata = {8'b0, precharge_q};
      default:             bus.rdata = '0;
    endcase
  end

  assign cfg_o.mode      = mode_q;
  assign cfg_o.direct    = direct_q;
  assign cfg_o.aperture  = aperture_q;
  assign cfg_o.precharge = precharge_q;

  ////////////////////////////////////////
  // spi line routing, live pins

  assign glb_spi_clk_o         = (spi_mux_q == 32'd0) ? 1'b1 : sck_i;   // park hi
  assign glb_spi_mosi_o        = (spi_mux_q == 32'd0) ? 1'b1 : sdi_i;   // park hi
  assign glb_4094_strobe_ctl_o = (spi_mux_q == 32'd1) ? ~spi_cs2_i : 1'b0;   // active hi
  assign spi_dac_ss_o          = (spi_mux_q == 32'd2) ? spi_cs2_i : 1'b1;    // active lo
  assign glb_4094_oe_ctl_o     = reg_4094_q[0];

  // cs2 is shared, so strobe and dac select must never be live together
  assert property (@(posedge clk) disable iff (reset_i)
    !(glb_4094_strobe_ctl_o && !spi_dac_ss_o));

endmodule

// File: rtl/spi_frame_rx.sv
// spi frame receiver
`timescale 1ns/1ps
`include "ctl_consts.svh"

module spi_frame_rx (
  input  logic   clk,
  input  logic   reset_i,
  input  logic   sck_i,
  input  logic   ss_i,
  input  logic   sdi_i,
  output logic   sdo_o,
  spi_reg_if.rx  bus
);

  localparam int HDR_BITS = `CTL_FRAME_BITS - 32;   // flag + address

  ////////////////////////////////////////
  // pin synchronizers

  logic [2:0]  sck_sync_q;   // [1] synced, [2] one cycle older
  logic [2:0]  ss_sync_q;
  logic [1:0]  sdi_sync_q;
  logic        sck_rise;
  logic        sck_fall;
  logic        ss_rise;
  logic        selected;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sck_sync_q <= '0;
      ss_sync_q  <= '1;   // idle deselected, no false edge
      sdi_sync_q <= '0;
    end else begin
      sck_sync_q <= {sck_sync_q[1:0], sck_i};
      ss_sync_q  <= {ss_sync_q[1:0], ss_i};
      sdi_sync_q <= {sdi_sync_q[0], sdi_i};
    end
  end

  assign sck_rise = sck_sync_q[1] & ~sck_sync_q[2];
  assign sck_fall = ~sck_sync_q[1] & sck_sync_q[2];
  assign ss_rise  = ss_sync_q[1] & ~ss_sync_q[2];    // end of frame
  assign selected = ~ss_sync_q[1];                   // active low select

  ////////////////////////////////////////
  // bit counter and header

  logic [5:0]  bit_cnt_q;    // saturates, so long frames stay invalid
  logic        wr_flag_q;
  logic [6:0]  addr_q;
  logic [31:0] shift_q;      // payload, last 32 bits in
  logic [31:0] tx_q;
  logic        wr_stb_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      bit_cnt_q <= '0;
      wr_flag_q <= 1'b0;
      addr_q    <= '0;
    end else if (!selected) begin
      bit_cnt_q <= '0;
    end else if (sck_rise) begin
      if (bit_cnt_q != '1) begin
        bit_cnt_q <= bit_cnt_q + 6'd1;
      end
      if (bit_cnt_q == 6'(HDR_BITS - 1)) begin   // last header bit arriving
        {wr_flag_q, addr_q} <= {shift_q[6:0], sdi_sync_q[1]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (selected && sck_rise) begin
      shift_q <= {shift_q[30:0], sdi_sync_q[1]};   // msb first
    end
  end

  // read data out on sck falling, first data bit right after the header
  always_ff @(posedge clk) begin
    if (reset_i || !selected) begin
      tx_q <= '0;
    end else if (sck_fall) begin
      if (bit_cnt_q == 6'(HDR_BITS)) begin
        tx_q <= bus.rdata;            // addr_q settled a few clk ago
      end else begin
        tx_q <= {tx_q[30:0], 1'b0};
      end
    end
  end

  // commit only a full write frame, on release of select
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_stb_q <= 1'b0;
    end else begin
      wr_stb_q <= ss_rise && wr_flag_q && (bit_cnt_q == 6'(`CTL_FRAME_BITS));
    end
  end

  assign sdo_o      = tx_q[31];
  assign bus.wr_stb = wr_stb_q;
  assign bus.addr   = addr_q;
  assign bus.wdata  = shift_q;

  // one strobe per frame, three clk after ss_i rises at the pin
  assert property (@(posedge clk) disable iff (reset_i) wr_stb_q |=> !wr_stb_q);
  assert property (@(posedge clk) disable iff (reset_i)
    wr_stb_q |-> $past(ss_i, 3) && !$past(ss_i, 4));

endmodule

// File: rtl/spi_reg_if.sv
// spi register access bus
`timescale 1ns/1ps

interface spi_reg_if;

  logic        wr_stb;   // single cycle, always accepted
  logic [6:0]  addr;     // held from header until next frame
  logic [31:0] wdata;
  logic [31:0] rdata;    // comb read of addr

  modport rx (
    output wr_stb,
    output addr,
    output wdata,
    input  rdata
  );

  modport regs (
    input  wr_stb,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: rtl/ctl_pkg.sv
// control core types
`include "ctl_consts.svh"

package ctl_pkg;

  // output mode, codes 5..7 unused
  typedef enum logic [2:0] {
    MODE_DIRECT  = `CTL_MODE_DIRECT,
    MODE_LO      = `CTL_MODE_LO,
    MODE_HI      = `CTL_MODE_HI,
    MODE_PATTERN = `CTL_MODE_PATTERN,
    MODE_PC      = `CTL_MODE_PC
  } mode_e;

  // register contents seen by the datapath
  typedef struct packed {
    mode_e       mode;
    logic [31:0] direct;
    logic [31:0] aperture;    // sample phase length, clk cycles
    logic [23:0] precharge;   // precharge phase length, clk cycles
  } cfg_t;

  // pin vector, leds at bit 0
  typedef struct packed {
    logic [3:0] adc_refmux;       // 24:21
    logic       adc_cmpr_latch;   // 20
    logic [3:0] azmux;            // 19:16
    logic [1:0] sig_pc_sw;        // 15:14
    logic       meas_complete;    // 13
    logic       spi_interrupt;    // 12
    logic [7:0] monitor;          // 11:4
    logic [3:0] leds;             // 3:0
  } pins_t;

endpackage

// File: include/ctl_consts.svh
// control core constants
`ifndef CTL_CONSTS_SVH
`define CTL_CONSTS_SVH

////////////////////////////////////////
// spi frame

`define CTL_FRAME_BITS      40          // 1 flag + 7 addr + 32 data

// register map, 7 bit addresses
`define CTL_ADDR_SPI_MUX    7'd0
`define CTL_ADDR_4094       7'd1
`define CTL_ADDR_MODE       7'd2
`define CTL_ADDR_DIRECT     7'd3
`define CTL_ADDR_STATUS     7'd4        // read only
`define CTL_ADDR_APERTURE   7'd5
`define CTL_ADDR_PRECHARGE  7'd6

`define CTL_MAGIC           8'hAA       // low byte of status

////////////////////////////////////////
// output modes

`define CTL_MODE_DIRECT     3'd0
`define CTL_MODE_LO         3'd1
`define CTL_MODE_HI         3'd2
`define CTL_MODE_PATTERN    3'd3
`define CTL_MODE_PC         3'd4

`define CTL_OUT_BITS        25          // analog control pin count

`endif
